// File: verilog/bp_consts.svh
`ifndef BP_CONSTS_SVH
`define BP_CONSTS_SVH

// pc and data width
`define BP_XLEN 32

// counter table split into banks by pc[3:2]
`define BP_BANKS 4
`define BP_BANK_W 2

// rows per bank, indexed by pc[11:4]
`define BP_ROW_W 8

// weakly not taken after reset
`define BP_CTR_INIT 2'd1

// trap handler entry
`define BP_EXCP_ADDR 32'h0000_1c00

`endif

// File: verilog/bp_pkg.sv
`include "bp_consts.svh"

package bp_pkg;

    typedef logic [`BP_XLEN-1:0] word_t;     // pc, imm, register data

    // 0 strong nt, 1 weak nt, 2 weak t, 3 strong t
    typedef logic [1:0] ctr_t;

    typedef logic [`BP_ROW_W-1:0] row_t;     // row inside one bank
    typedef logic [`BP_BANK_W-1:0] bank_sel_t;

    // kind of the fetch waiting for its counter, NONE when nothing is in flight
    typedef enum logic [1:0] {
        NONE,
        COND,
        JAL,
        JALR
    } fetch_kind_t;

endpackage

// File: verilog/pht_port_if.sv
`include "bp_consts.svh"

interface pht_port_if;
    import bp_pkg::*;

    // lookup side, from the router
    logic lookup_en;     // single cycle strobe
    row_t lookup_row;

    // training side, from the router
    logic update_en;
    row_t update_row;
    logic update_taken;

    // read data, one cycle after lookup_en
    logic rd_valid;
    ctr_t rd_ctr;

    modport router (
        output lookup_en,
        output lookup_row,
        output update_en,
        output update_row,
        output update_taken
    );

    modport bank (
        input  lookup_en,
        input  lookup_row,
        input  update_en,
        input  update_row,
        input  update_taken,
        output rd_valid,
        output rd_ctr
    );

    modport collector (
        input rd_valid,
        input rd_ctr
    );

endinterface

// File: verilog/pht_router.sv
`include "bp_consts.svh"

module pht_router (
    input  logic          clk,
    input  logic          rst,
    input  logic          fetch_valid,
    input  bp_pkg::word_t pc,
    input  logic          resolve_valid,
    input  bp_pkg::word_t resolve_pc,
    input  logic          resolve_taken,
    pht_port_if.router    ports [`BP_BANKS]
);
    import bp_pkg::*;

    localparam int BANK_LO = 2;                    // pc[1:0] always zero
    localparam int ROW_LO  = BANK_LO + `BP_BANK_W;

    logic      start_flag;   // low in the first cycle out of reset
    logic      fetch_ok;
    logic      update_ok;
    bank_sel_t fetch_bank;
    row_t      fetch_row;
    bank_sel_t upd_bank;
    row_t      upd_row;

    always_ff @(posedge clk) begin
        if (rst) begin
            start_flag <= 1'b0;
        end else begin
            start_flag <= 1'b1;
        end
    end

    // word index split, bank from the low bits so neighbours spread out
    assign fetch_bank = pc[ROW_LO-1:BANK_LO];
    assign fetch_row  = pc[ROW_LO+`BP_ROW_W-1:ROW_LO];
    assign upd_bank   = resolve_pc[ROW_LO-1:BANK_LO];
    assign upd_row    = resolve_pc[ROW_LO+`BP_ROW_W-1:ROW_LO];

    assign fetch_ok  = fetch_valid && start_flag;
    assign update_ok = resolve_valid && start_flag; // only conditional resolves come in

    for (genvar i = 0; i < `BP_BANKS; i++) begin : g_port
        assign ports[i].lookup_en    = fetch_ok && (fetch_bank == bank_sel_t'(i));
        assign ports[i].lookup_row   = fetch_row;
        assign ports[i].update_en    = update_ok && (upd_bank == bank_sel_t'(i));
        assign ports[i].update_row   = upd_row;
        assign ports[i].update_taken = resolve_taken;
    end

endmodule

// File: verilog/pht_bank.sv
`include "bp_consts.svh"

module pht_bank (
    input  logic     clk,
    input  logic     rst,
    pht_port_if.bank port
);
    import bp_pkg::*;

    localparam int ROWS = 1 << `BP_ROW_W;

    ctr_t ctr_mem [ROWS];
    ctr_t cur_ctr;      // entry being trained
    ctr_t next_ctr;

    // saturating step of the trained entry
    assign cur_ctr = ctr_mem[port.update_row];

    always_comb begin
        next_ctr = cur_ctr;
        if (port.update_taken) begin
            if (cur_ctr != 2'd3) begin
                next_ctr = cur_ctr + 2'd1;
            end
        end else if (cur_ctr != 2'd0) begin
            next_ctr = cur_ctr - 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < ROWS; i++) begin
                ctr_mem[i] <= `BP_CTR_INIT;
            end
        end else if (port.update_en) begin
            ctr_mem[port.update_row] <= next_ctr;
        end
    end

    // registered read, a same-cycle update is not seen
    always_ff @(posedge clk) begin
        if (rst) begin
            port.rd_valid <= 1'b0;
        end else begin
            port.rd_valid <= port.lookup_en;
        end
    end

    always_ff @(posedge clk) begin
        if (port.lookup_en) begin
            port.rd_ctr <= ctr_mem[port.lookup_row];
        end
    end

endmodule

// File: verilog/next_pc_unit.sv
`include "bp_consts.svh"

module next_pc_unit (
    input  logic          clk,
    input  logic          rst,
    input  logic          fetch_valid,
    input  bp_pkg::word_t pc,
    input  logic          branch,
    input  logic          predict,
    input  logic          ujtype,
    input  bp_pkg::word_t imm,
    input  bp_pkg::word_t rs1_data,
    input  logic          resolve_valid,
    input  bp_pkg::word_t resolve_target,
    input  logic          resolve_predicted,
    input  logic          resolve_taken,
    input  logic          excp,
    pht_port_if.collector banks [`BP_BANKS],
    output logic          pred_valid,
    output logic          redirect,
    output logic          predict_result,
    output logic          predict_fail,
    output bp_pkg::word_t target_pc,
    output bp_pkg::word_t sepc
);
    import bp_pkg::*;

    fetch_kind_t fetch_kind;
    fetch_kind_t kind_q;
    logic        fetch_q;
    logic        excp_q;
    logic        miss_q;
    logic        miss_taken_q;
    word_t       pc_q;
    word_t       imm_q;
    word_t       rs1_q;
    word_t       miss_target_q;
    ctr_t        bank_ctr [`BP_BANKS];
    ctr_t        ctr_sel;
    logic        pred_taken;
    word_t       pred_pc;

    // same split as the control decode: branch+predict is a conditional
    always_comb begin
        unique case ({branch, predict})
            2'b11:   fetch_kind = COND;
            2'b10:   fetch_kind = ujtype ? JAL : JALR;
            default: fetch_kind = NONE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_q <= 1'b0;
            kind_q  <= NONE;
            excp_q  <= 1'b0;
            miss_q  <= 1'b0;
            sepc    <= '0;
        end else begin
            fetch_q <= fetch_valid;
            kind_q  <= fetch_valid ? fetch_kind : NONE;
            excp_q  <= excp;
            miss_q  <= resolve_valid && (resolve_predicted != resolve_taken);
            if (excp) begin
                sepc <= pc + word_t'(4);   // return past the trapping instruction
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_valid) begin
            pc_q  <= pc;
            imm_q <= imm;
            rs1_q <= rs1_data;
        end
        if (resolve_valid) begin
            miss_target_q <= resolve_target;
            miss_taken_q  <= resolve_taken;
        end
    end

    // only the looked-up bank answers, the others give zero
    for (genvar i = 0; i < `BP_BANKS; i++) begin : g_sel
        assign bank_ctr[i] = banks[i].rd_valid ? banks[i].rd_ctr : '0;
    end

    always_comb begin
        ctr_sel = '0;
        for (int i = 0; i < `BP_BANKS; i++) begin
            ctr_sel = ctr_sel | bank_ctr[i];
        end
    end

    always_comb begin
        unique case (kind_q)
            COND: begin
                pred_taken = ctr_sel >= 2'd2;  // upper half of the counter
                pred_pc    = pred_taken ? pc_q + imm_q : pc_q + word_t'(4);
            end
            JAL: begin
                pred_taken = 1'b1;
                pred_pc    = pc_q + imm_q;
            end
            JALR: begin
                pred_taken = 1'b1;
                pred_pc    = rs1_q + imm_q;
            end
            default: begin
                pred_taken = 1'b0;
                pred_pc    = pc_q + word_t'(4);
            end
        endcase
    end

    // exception beats mispredict beats prediction
    assign pred_valid   = fetch_q;
    assign redirect     = excp_q || miss_q;
    assign predict_fail = miss_q && !excp_q;

    always_comb begin
        if (excp_q) begin
            predict_result = 1'b0;
            target_pc      = `BP_EXCP_ADDR;
        end else if (miss_q) begin
            predict_result = miss_taken_q;   // actual outcome goes back to EX
            target_pc      = miss_target_q;
        end else begin
            predict_result = pred_taken;
            target_pc      = pred_pc;
        end
    end

endmodule

// File: verilog/branch_predictor.sv
`include "bp_consts.svh"

module branch_predictor (
    input  logic          clk,
    input  logic          rst,
    // fetch side
    input  logic          fetch_valid,
    input  bp_pkg::word_t pc,
    input  logic          branch,
    input  logic          predict,
    input  logic          ujtype,
    input  bp_pkg::word_t imm,
    input  bp_pkg::word_t rs1_data,
    // resolved branch from execute
    input  logic          resolve_valid,
    input  bp_pkg::word_t resolve_pc,
    input  bp_pkg::word_t resolve_target,
    input  logic          resolve_predicted,
    input  logic          resolve_taken,
    input  logic          excp,
    // next pc towards fetch
    output logic          pred_valid,
    output logic          redirect,
    output logic          predict_result,
    output logic          predict_fail,
    output bp_pkg::word_t target_pc,
    output bp_pkg::word_t sepc
);

    pht_port_if pht_ports [`BP_BANKS] ();   // one port per counter bank

    pht_router u_router (
        .clk           (clk),
        .rst           (rst),
        .fetch_valid   (fetch_valid),
        .pc            (pc),
        .resolve_valid (resolve_valid),
        .resolve_pc    (resolve_pc),
        .resolve_taken (resolve_taken),
        .ports         (pht_ports)
    );

    for (genvar i = 0; i < `BP_BANKS; i++) begin : g_bank
        pht_bank u_bank (
            .clk  (clk),
            .rst  (rst),
            .port (pht_ports[i])
        );
    end

    next_pc_unit u_next_pc (
        .clk               (clk),
        .rst               (rst),
        .fetch_valid       (fetch_valid),
        .pc                (pc),
        .branch            (branch),
        .predict           (predict),
        .ujtype            (ujtype),
        .imm               (imm),
        .rs1_data          (rs1_data),
        .resolve_valid     (resolve_valid),
        .resolve_target    (resolve_target),
        .resolve_predicted (resolve_predicted),
        .resolve_taken     (resolve_taken),
        .excp              (excp),
        .banks             (pht_ports),
        .pred_valid        (pred_valid),
        .redirect          (redirect),
        .predict_result    (predict_result),
        .predict_fail      (predict_fail),
        .target_pc         (target_pc),
        .sepc              (sepc)
    );

endmodule

// File: tb/branch_predictor_assert.sv
`include "bp_consts.svh"

module branch_predictor_assert (
    input logic                 clk,
    input logic                 rst,
    input logic                 fetch_valid,
    input logic                 pred_valid,
    input logic                 redirect,
    input logic                 predict_fail,
    input logic [`BP_BANKS-1:0] rd_valid
);
    timeunit 1ns;
    timeprecision 1ps;

    // prediction comes back exactly one cycle after the fetch strobe
    a_pred_after_fetch: assert property (
        @(posedge clk) disable iff (rst) fetch_valid |=> pred_valid
    ) else $error("pred_valid missing one cycle after fetch_valid");

    a_no_pred_without_fetch: assert property (
        @(posedge clk) disable iff (rst) !fetch_valid |=> !pred_valid
    ) else $error("pred_valid without a fetch_valid one cycle before");

    // only one bank was looked up, so only one answers
    a_single_bank_read: assert property (
        @(posedge clk) disable iff (rst) $onehot0(rd_valid)
    ) else $error("more than one bank raised rd_valid");

    a_fail_redirects: assert property (
        @(posedge clk) disable iff (rst) predict_fail |-> redirect
    ) else $error("predict_fail high without redirect");

endmodule

// File: tb/branch_predictor_tb.sv
`include "bp_consts.svh"

module branch_predictor_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import bp_pkg::*;

    localparam int TIMEOUT = 10;          // cycles allowed for any response
    localparam int ENTRIES = 1024;

    logic  clk;
    logic  rst;
    logic  fetch_valid;
    word_t pc;
    logic  branch;
    logic  predict;
    logic  ujtype;
    word_t imm;
    word_t rs1_data;
    logic  resolve_valid;
    word_t resolve_pc;
    word_t resolve_target;
    logic  resolve_predicted;
    logic  resolve_taken;
    logic  excp;
    logic  pred_valid;
    logic  redirect;
    logic  predict_result;
    logic  predict_fail;
    word_t target_pc;
    word_t sepc;

    ctr_t model [ENTRIES];   // expected counter per word index pc[11:2]
    int   errors;
    int   checks;

    branch_predictor UUT (.*);

    bind branch_predictor branch_predictor_assert u_assert (
        .clk          (clk),
        .rst          (rst),
        .fetch_valid  (fetch_valid),
        .pred_valid   (pred_valid),
        .redirect     (redirect),
        .predict_fail (predict_fail),
        .rd_valid     ({pht_ports[3].rd_valid, pht_ports[2].rd_valid,
                        pht_ports[1].rd_valid, pht_ports[0].rd_valid})
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic int entry_of(word_t a);
        return int'(a[11:2]);
    endfunction

    // 2-bit saturating counter moves up on taken and down on not taken
    function automatic ctr_t saturate_step(ctr_t c, logic taken);
        if (taken) begin
            return (c == 2'd3) ? c : c + 2'd1;
        end
        return (c == 2'd0) ? c : c - 2'd1;
    endfunction

    function automatic word_t rand_pc();
        return word_t'($urandom) & ~word_t'(3);
    endfunction

    task automatic check_word(string name, word_t got, word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    // cycles is 0 when pred_valid never came
    task automatic wait_pred(output int cycles);
        cycles = 0;
        for (int n = 1; n <= TIMEOUT; n++) begin
            @(negedge clk);
            if (pred_valid) begin
                cycles = n;
                break;
            end
        end
        if (cycles == 0) begin
            errors++;
            $display("timeout: pred_valid did not rise within %0d cycles", TIMEOUT);
        end
    endtask

    task automatic wait_redirect(output logic seen);
        int cycles;
        seen   = 1'b0;
        cycles = 0;
        for (int n = 1; n <= TIMEOUT; n++) begin
            @(negedge clk);
            if (redirect) begin
                seen   = 1'b1;
                cycles = n;
                break;
            end
        end
        if (!seen) begin
            errors++;
            $display("timeout: redirect did not rise within %0d cycles", TIMEOUT);
        end else if (cycles != 1) begin
            errors++;
            $display("redirect came %0d cycles after the strobe instead of 1", cycles);
        end
    endtask

    task automatic fetch_and_check(word_t fpc, logic br, logic pr, logic uj, word_t fimm,
                                   word_t frs1, logic exp_taken, word_t exp_target);
        int cycles;
        @(posedge clk);
        fetch_valid <= 1'b1;
        pc          <= fpc;
        branch      <= br;
        predict     <= pr;
        ujtype      <= uj;
        imm         <= fimm;
        rs1_data    <= frs1;
        @(posedge clk);
        fetch_valid <= 1'b0;
        wait_pred(cycles);
        if (cycles != 0) begin
            if (cycles != 1) begin
                errors++;
                $display("prediction for pc 0x%08h took %0d cycles instead of 1", fpc, cycles);
            end
            check_bit("predict_result", predict_result, exp_taken);
            check_word("target_pc", target_pc, exp_target);
            check_bit("redirect", redirect, 1'b0);
        end
    endtask

    // conditional branch with the expected outcome taken from the counter model
    task automatic predict_cond(word_t fpc, word_t fimm);
        logic taken;
        taken = model[entry_of(fpc)] >= 2'd2;
        fetch_and_check(fpc, 1'b1, 1'b1, 1'b0, fimm, '0, taken,
                        taken ? fpc + fimm : fpc + 32'd4);
    endtask

    task automatic send_resolve(word_t rpc, logic rtaken, logic rpred, word_t rtgt);
        logic seen;
        @(posedge clk);
        resolve_valid     <= 1'b1;
        resolve_pc        <= rpc;
        resolve_taken     <= rtaken;
        resolve_predicted <= rpred;
        resolve_target    <= rtgt;
        @(posedge clk);
        resolve_valid <= 1'b0;
        model[entry_of(rpc)] = saturate_step(model[entry_of(rpc)], rtaken);
        if (rpred != rtaken) begin
            wait_redirect(seen);
            if (seen) begin
                check_bit("predict_fail", predict_fail, 1'b1);
                check_bit("predict_result", predict_result, rtaken);
                check_word("target_pc", target_pc, rtgt);
            end
        end else begin
            @(negedge clk);   // a correct prediction gives no redirect in t+1
            check_bit("redirect", redirect, 1'b0);
        end
    endtask

    task automatic train(word_t rpc, logic rtaken);
        logic rpred;
        rpred = model[entry_of(rpc)] >= 2'd2;
        send_resolve(rpc, rtaken, rpred, rtaken ? rpc + 32'h40 : rpc + 32'd4);
    endtask

    task automatic test_reset_predict();
        word_t fpc;
        fpc = rand_pc();
        fetch_and_check(fpc, 1'b1, 1'b1, 1'b0, word_t'($urandom) & ~word_t'(1), '0,
                        1'b0, fpc + 32'd4);
    endtask

    task automatic test_jumps();
        word_t fpc;
        word_t fimm;
        word_t frs1;
        fpc  = rand_pc();
        fimm = word_t'($urandom) & ~word_t'(1);
        frs1 = word_t'($urandom);
        fetch_and_check(fpc, 1'b1, 1'b0, 1'b1, fimm, frs1, 1'b1, fpc + fimm);   // jal
        fetch_and_check(fpc, 1'b1, 1'b0, 1'b0, fimm, frs1, 1'b1, frs1 + fimm);  // jalr
        fetch_and_check(fpc, 1'b0, 1'b0, 1'b0, fimm, frs1, 1'b0, fpc + 32'd4);
    endtask

    task automatic test_training();
        word_t fpc;
        word_t fimm;
        fpc  = rand_pc();
        fimm = word_t'($urandom) & ~word_t'(1);
        repeat (4) begin   // the first reaches weak taken and the rest push against the ceiling
            train(fpc, 1'b1);
            predict_cond(fpc, fimm);
        end
        check_word("target_pc after taken training", target_pc, fpc + fimm);
        repeat (3) begin
            train(fpc, 1'b0);
            predict_cond(fpc, fimm);
        end
        check_word("target_pc after not-taken training", target_pc, fpc + 32'd4);
    endtask

    task automatic test_banks();
        word_t base;
        base = word_t'($urandom) & ~word_t'(32'hf);
        train(base + 32'd4, 1'b1);
        train(base + 32'd4, 1'b1);
        train(base + 32'd12, 1'b0);
        for (int i = 0; i < `BP_BANKS; i++) begin
            predict_cond(base + word_t'(4 * i), 32'h100);
        end
    endtask

    task automatic test_mispredict();
        word_t rpc;
        rpc = rand_pc();
        send_resolve(rpc, 1'b0, 1'b1, rpc + 32'd4);
        send_resolve(rpc, 1'b1, 1'b0, rand_pc());
    endtask

    task automatic test_exception();
        word_t epc;
        word_t rpc;
        logic  seen;
        epc = rand_pc();
        @(posedge clk);
        excp <= 1'b1;
        pc   <= epc;
        @(posedge clk);
        excp <= 1'b0;
        wait_redirect(seen);
        if (seen) begin
            check_word("target_pc", target_pc, `BP_EXCP_ADDR);
            check_bit("predict_fail", predict_fail, 1'b0);
            check_word("sepc", sepc, epc + 32'd4);
        end
        // the trap wins over a mispredict in the same cycle
        epc = rand_pc();
        rpc = rand_pc();
        @(posedge clk);
        excp              <= 1'b1;
        pc                <= epc;
        resolve_valid     <= 1'b1;
        resolve_pc        <= rpc;
        resolve_taken     <= 1'b1;
        resolve_predicted <= 1'b0;
        resolve_target    <= rpc + 32'h80;
        @(posedge clk);
        excp          <= 1'b0;
        resolve_valid <= 1'b0;
        model[entry_of(rpc)] = saturate_step(model[entry_of(rpc)], 1'b1);
        wait_redirect(seen);
        if (seen) begin
            check_word("target_pc", target_pc, `BP_EXCP_ADDR);
            check_bit("predict_fail", predict_fail, 1'b0);
            check_word("sepc", sepc, epc + 32'd4);
        end
        predict_cond(rpc, 32'h20);   // the resolve still trained its counter
    endtask

    initial begin
        void'($urandom(32'h7f603105));
        errors            = 0;
        checks            = 0;
        rst               = 1'b1;
        fetch_valid       = 1'b0;
        pc                = '0;
        branch            = 1'b0;
        predict           = 1'b0;
        ujtype            = 1'b0;
        imm               = '0;
        rs1_data          = '0;
        resolve_valid     = 1'b0;
        resolve_pc        = '0;
        resolve_target    = '0;
        resolve_predicted = 1'b0;
        resolve_taken     = 1'b0;
        excp              = 1'b0;
        for (int i = 0; i < ENTRIES; i++) begin
            model[i] = `BP_CTR_INIT;
        end
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        repeat (2) @(posedge clk);   // router guard opens one cycle after reset

        test_reset_predict();
        test_jumps();
        test_training();
        test_banks();
        test_mispredict();
        test_exception();

        repeat (2) @(posedge clk);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: src.f
+incdir+verilog
verilog/bp_pkg.sv
verilog/pht_port_if.sv
verilog/pht_router.sv
verilog/pht_bank.sv
verilog/next_pc_unit.sv
verilog/branch_predictor.sv
tb/branch_predictor_assert.sv
tb/branch_predictor_tb.sv
